// ==== list.f ====
logic/cache_pkg.sv
logic/cpu_port.sv
logic/way_store.sv
logic/hit_lru_unit.sv
logic/line_update.sv
logic/cache_fsm.sv
logic/mem_port.sv
logic/cache_top.sv
tb/mem_model.sv
tb/cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cache_tb
LOG       ?= sim.log
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' list.f)

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): list.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f list.f

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q '^STATUS: PASS$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb/cache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_tb;

  localparam int num_ops    = 800;
  localparam int max_cycles = num_ops * 40;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               cpu_req_valid, cpu_req_ready, cpu_rsp_valid, cpu_rsp_ready;
  cache_pkg::cpu_op_e cpu_req_op;
  cache_pkg::word_t   cpu_req_addr, cpu_req_wdata, cpu_rsp_rdata, mem_req_addr;
  logic               mem_req_valid, mem_req_ready, mem_req_write, mem_rsp_valid;
  cache_pkg::block_t  mem_req_wblock, mem_rsp_rblock;

  // Shadow of CPU-visible words and of each set's tags, dirty bits and ages
  cache_pkg::word_t shadow_mem [cache_pkg::word_t];
  cache_pkg::tag_t  sh_tag   [cache_pkg::sets][cache_pkg::ways];
  logic             sh_valid [cache_pkg::sets][cache_pkg::ways];
  logic             sh_dirty [cache_pkg::sets][cache_pkg::ways];
  int               sh_age   [cache_pkg::sets][cache_pkg::ways];

  logic              exp_hit, exp_wb, exp_read;  // Prediction for the access in flight
  cache_pkg::word_t  exp_rdata, exp_wb_addr, exp_fill_addr;
  cache_pkg::block_t exp_wb_block;
  logic              busy;
  int                cycle_cnt, accept_cnt, wb_seen, fill_seen;
  logic [31:0]       rng;

  always #2 clk = ~clk;  // 4 ns period

  cache_top dut0 (.*);

  mem_model mem0 (
    .clk, .rst_n, .req_valid(mem_req_valid), .req_ready(mem_req_ready),
    .req_write(mem_req_write), .req_addr(mem_req_addr), .req_wblock(mem_req_wblock),
    .rsp_valid(mem_rsp_valid), .rsp_rblock(mem_rsp_rblock)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic cache_pkg::word_t init_word(input cache_pkg::word_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h3c6e_f372;  // Memory fill pattern
  endfunction

  function automatic cache_pkg::word_t shadow_word(input cache_pkg::word_t addr);
    return shadow_mem.exists(addr) ? shadow_mem[addr] : init_word(addr);
  endfunction

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
    stop_run($sformatf("MISMATCH time=%0t %s expected=%0h got=%0h",
                       $time, name, expected, actual));
  endtask

  // Predicts hit, victim and memory traffic, then moves the shadow on
  task automatic predict(input cache_pkg::cpu_op_e op, input cache_pkg::word_t addr,
                         input cache_pkg::word_t wdata);
    cache_pkg::tag_t   tag;
    cache_pkg::index_t idx;
    int                tgt;
    int                old_age;
    tag = addr[cache_pkg::word_bits-1 -: cache_pkg::tag_bits];
    idx = addr[cache_pkg::offset_bits +: cache_pkg::index_bits];
    tgt = -1;
    for (int w = 0; w < cache_pkg::ways; w++) begin
      if (sh_valid[idx][w] && sh_tag[idx][w] == tag) tgt = w;
    end
    exp_hit       = (tgt >= 0);
    exp_read      = (op == cache_pkg::op_read);
    exp_rdata     = shadow_word(addr);
    exp_fill_addr = {tag, idx, 2'b00};
    exp_wb        = 1'b0;
    if (!exp_hit) begin
      for (int w = cache_pkg::ways - 1; w >= 0; w--) begin
        if (!sh_valid[idx][w]) tgt = w;  // Lowest invalid way first
      end
      for (int w = 0; w < cache_pkg::ways; w++) begin
        if (tgt < 0 && sh_age[idx][w] == 3) tgt = w;
      end
      exp_wb      = sh_valid[idx][tgt] && sh_dirty[idx][tgt];
      exp_wb_addr = {sh_tag[idx][tgt], idx, 2'b00};  // Victim's own block
      for (int k = 0; k < 4; k++) exp_wb_block[k*32 +: 32] = shadow_word(exp_wb_addr + 32'(k));
    end
    old_age = sh_valid[idx][tgt] ? sh_age[idx][tgt] : 4;
    for (int w = 0; w < cache_pkg::ways; w++) begin
      if (w != tgt && sh_valid[idx][w] && sh_age[idx][w] < old_age)
        sh_age[idx][w] = sh_age[idx][w] + 1;
    end
    sh_age[idx][tgt]   = 0;
    sh_dirty[idx][tgt] = !exp_read || (exp_hit && sh_dirty[idx][tgt]);
    sh_valid[idx][tgt] = 1'b1;
    sh_tag[idx][tgt]   = tag;
    if (!exp_read) shadow_mem[addr] = wdata;
  endtask

  // Cycle count and memory traffic of the access in flight
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt  <= 0;
      accept_cnt <= 0;
      busy       <= 1'b0;
      wb_seen    <= 0;
      fill_seen  <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
      if (cpu_req_valid && cpu_req_ready) begin
        busy       <= 1'b1;
        accept_cnt <= cycle_cnt;
        wb_seen    <= 0;
        fill_seen  <= 0;
      end else if (mem_req_valid && mem_req_ready) begin
        if (mem_req_write) wb_seen <= wb_seen + 1;
        else fill_seen <= fill_seen + 1;
      end
      if (cpu_rsp_valid && cpu_rsp_ready) busy <= 1'b0;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    cpu_rsp_valid && cpu_rsp_ready && exp_read |-> cpu_rsp_rdata == exp_rdata)
    else report_mismatch("cpu_rsp_rdata", 128'(exp_rdata), 128'($sampled(cpu_rsp_rdata)));

  // Valid set at the second edge after acceptance, first sampled at the third
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cpu_rsp_valid) && exp_hit |-> cycle_cnt - accept_cnt == 3)
    else report_mismatch("cpu_rsp_valid delay", 128'd2,
                         128'($sampled(cycle_cnt) - $sampled(accept_cnt) - 1));

  assert property (@(posedge clk) disable iff (!rst_n) busy && exp_hit |-> !mem_req_valid)
    else stop_run("memory request issued on a predicted hit");

  assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_valid && mem_req_ready && mem_req_write |-> exp_wb)
    else stop_run("write-back issued although the victim is clean or invalid");

  assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_valid && mem_req_ready && mem_req_write |-> mem_req_addr == exp_wb_addr)
    else report_mismatch("mem_req_addr", 128'(exp_wb_addr), 128'($sampled(mem_req_addr)));

  assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_valid && mem_req_ready && mem_req_write |-> mem_req_wblock == exp_wb_block)
    else report_mismatch("mem_req_wblock", exp_wb_block, $sampled(mem_req_wblock));

  assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_valid && mem_req_ready && !mem_req_write |-> mem_req_addr == exp_fill_addr)
    else report_mismatch("mem_req_addr", 128'(exp_fill_addr), 128'($sampled(mem_req_addr)));

  // One fill per miss, one write-back per dirty victim
  assert property (@(posedge clk) disable iff (!rst_n)
    cpu_rsp_valid && cpu_rsp_ready |-> wb_seen == int'(exp_wb) && fill_seen == int'(!exp_hit))
    else stop_run("memory traffic of the access differs from the prediction");

  assert property (@(posedge clk) disable iff (!rst_n)
    cpu_rsp_valid && !cpu_rsp_ready |=> cpu_rsp_valid && $stable(cpu_rsp_rdata))
    else stop_run("response dropped or changed while the CPU stalled it");

  assert property (@(posedge clk) disable iff (!rst_n) cpu_rsp_valid |-> !cpu_req_ready)
    else stop_run("request ready while a response is pending");

  initial begin
    cache_pkg::tag_t tag;
    rst_n         = 1'b0;
    cpu_req_valid = 1'b0;
    cpu_req_op    = cache_pkg::op_read;
    cpu_req_addr  = '0;
    cpu_req_wdata = '0;
    cpu_rsp_ready = 1'b0;
    rng           = 32'ha85c_439c;
    exp_hit       = 1'b0;
    exp_wb        = 1'b0;
    exp_read      = 1'b0;
    for (int s = 0; s < cache_pkg::sets; s++) begin
      for (int w = 0; w < cache_pkg::ways; w++) begin
        sh_valid[s][w] = 1'b0;
        sh_dirty[s][w] = 1'b0;
        sh_age[s][w]   = 0;
        sh_tag[s][w]   = '0;
      end
    end
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (cpu_req_ready && !cpu_rsp_valid && !mem_req_valid)
      else stop_run("handshake outputs wrong after reset");
    for (int n = 0; n < num_ops; n++) begin
      rng = lcg_next(rng);
      tag = cache_pkg::tag_t'(rng[31:24] % 8'd5) * 26'h0a5_3c1;  // Five tags per set
      cpu_req_addr = {tag, rng[23:20], rng[19:18]};
      cpu_req_op   = rng[17] ? cache_pkg::op_write : cache_pkg::op_read;
      rng = lcg_next(rng);
      cpu_req_wdata = rng;
      predict(cpu_req_op, cpu_req_addr, cpu_req_wdata);
      cpu_req_valid = 1'b1;
      while (!cpu_req_ready) @(negedge clk);
      @(negedge clk);                        // Accepted at the edge just passed
      cpu_req_valid = 1'b0;
      rng = lcg_next(rng);
      cpu_rsp_ready = (rng[31:30] != 2'b00);
      while (!(cpu_rsp_valid && cpu_rsp_ready)) begin
        @(negedge clk);
        rng = lcg_next(rng);
        cpu_rsp_ready = (rng[31:30] != 2'b00);  // Stall about one cycle in four
      end
      @(negedge clk);
    end
    $display("STATUS: PASS");
    $finish;
  end

  initial begin
    #(4 * max_cycles);
    stop_run($sformatf("timeout, %0d operations not done in %0d cycles", num_ops, max_cycles));
  end

endmodule

`default_nettype wire

// ==== tb/mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_model (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_valid,
  output logic                 req_ready,
  input  logic                 req_write,
  input  cache_pkg::word_t     req_addr,
  input  cache_pkg::block_t    req_wblock,
  output logic                 rsp_valid,
  output cache_pkg::block_t    rsp_rblock
);

  cache_pkg::word_t  mem [cache_pkg::word_t];  // Only written words are kept
  cache_pkg::block_t rdata_q;                   // Block for the pending response
  logic [31:0]       rng;
  int                wait_cnt;                  // Cycles to the response, 0 when idle

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Odd multiplier, so every address bit changes the word
  function automatic cache_pkg::word_t init_word(input cache_pkg::word_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h3c6e_f372;
  endfunction

  function automatic cache_pkg::block_t read_block(input cache_pkg::word_t base);
    cache_pkg::block_t blk;
    cache_pkg::word_t  a;
    for (int k = 0; k < 4; k++) begin
      a = base + 32'(k);
      blk[k*32 +: 32] = mem.exists(a) ? mem[a] : init_word(a);
    end
    return blk;
  endfunction

  initial begin
    req_ready  = 1'b0;
    rsp_valid  = 1'b0;
    rsp_rblock = '0;
    rdata_q    = '0;
    rng        = ~32'ha85c_439c;  // Own stream, apart from the CPU side
    wait_cnt   = 0;
  end

  always @(negedge clk) begin
    rsp_valid = 1'b0;                // Pulse lasts one cycle
    if (wait_cnt > 0) begin
      req_ready = 1'b0;              // One request at a time
      wait_cnt  = wait_cnt - 1;
      if (wait_cnt == 0) begin
        rsp_valid  = 1'b1;
        rsp_rblock = rdata_q;
      end
    end else begin
      rng       = lcg_next(rng);
      req_ready = rng[31];           // Random back-pressure
      if (rst_n && req_valid && req_ready) begin
        // Handshake lands on the coming rising edge
        if (req_write) begin
          for (int k = 0; k < 4; k++) mem[req_addr + 32'(k)] = req_wblock[k*32 +: 32];
          rdata_q = '0;
        end else begin
          rdata_q = read_block(req_addr);
        end
        wait_cnt = 1 + int'(rng[29:28]);  // 1 to 4 cycles
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/cache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cpu_req_valid,
  output logic                 cpu_req_ready,
  input  cache_pkg::cpu_op_e   cpu_req_op,
  input  cache_pkg::word_t     cpu_req_addr,
  input  cache_pkg::word_t     cpu_req_wdata,
  output logic                 cpu_rsp_valid,
  output cache_pkg::word_t     cpu_rsp_rdata,
  input  logic                 cpu_rsp_ready,
  output logic                 mem_req_valid,
  input  logic                 mem_req_ready,
  output logic                 mem_req_write,
  output cache_pkg::word_t     mem_req_addr,
  output cache_pkg::block_t    mem_req_wblock,
  input  logic                 mem_rsp_valid,
  input  cache_pkg::block_t    mem_rsp_rblock
);

  logic idle, rsp_load, req_fire, rsp_done, hit, need_write_back;
  logic wr_en, new_dirty, mem_start, mem_write, hit_dirty;
  cache_pkg::cpu_op_e       req_op;
  cache_pkg::tag_t          req_tag, victim_tag;
  cache_pkg::index_t        req_index;
  cache_pkg::offset_t       req_offset;
  cache_pkg::word_t         req_wdata, rsp_word;
  cache_pkg::way_vec_t      line_valid, line_dirty, hit_way, victim_way, target_way;
  cache_pkg::age_t   [cache_pkg::ways-1:0] line_age, new_age;
  cache_pkg::tag_t   [cache_pkg::ways-1:0] line_tag;
  cache_pkg::block_t [cache_pkg::ways-1:0] line_block;
  cache_pkg::block_t        victim_block, hit_block, new_block, fill_block;

  // Hit way's block and dirty bit for the merge
  assign hit_block = hit_way[0] ? line_block[0] : hit_way[1] ? line_block[1] :
                     hit_way[2] ? line_block[2] : line_block[3];
  assign hit_dirty = |(hit_way & line_dirty);

  cpu_port u_cpu_port (
    .clk, .rst_n, .cpu_req_valid, .cpu_req_ready, .cpu_req_op, .cpu_req_addr,
    .cpu_req_wdata, .cpu_rsp_valid, .cpu_rsp_rdata, .cpu_rsp_ready,
    .idle, .rsp_load, .rsp_word, .req_fire, .req_op, .req_tag, .req_index,
    .req_offset, .req_wdata, .rsp_done
  );

  way_store u_way_store (
    .clk, .rst_n, .rd_index(req_index), .line_valid, .line_dirty, .line_age,
    .line_tag, .line_block, .wr_en, .wr_way(target_way), .wr_tag(req_tag),
    .wr_block(new_block), .wr_dirty(new_dirty), .new_age
  );

  hit_lru_unit u_hit_lru (
    .req_tag, .line_valid, .line_dirty, .line_age, .line_tag, .line_block,
    .hit_way, .hit, .victim_way, .need_write_back, .victim_tag, .victim_block,
    .target_way, .new_age
  );

  line_update u_line_update (
    .req_op, .req_offset, .req_wdata, .hit, .hit_dirty, .hit_block, .fill_block,
    .new_block, .new_dirty, .rsp_word
  );

  cache_fsm u_fsm (
    .clk, .rst_n, .req_fire, .hit, .need_write_back, .mem_rsp_valid, .rsp_done,
    .state(), .idle, .mem_start, .mem_write, .wr_en, .rsp_load
  );

  mem_port u_mem_port (
    .clk, .rst_n, .mem_start, .mem_write, .req_tag, .req_index, .victim_tag,
    .victim_block, .mem_req_valid, .mem_req_ready, .mem_req_write, .mem_req_addr,
    .mem_req_wblock, .mem_rsp_valid, .mem_rsp_rblock, .fill_block
  );

endmodule

`default_nettype wire

// ==== logic/mem_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 mem_start,
  input  logic                 mem_write,
  input  cache_pkg::tag_t      req_tag,
  input  cache_pkg::index_t    req_index,
  input  cache_pkg::tag_t      victim_tag,
  input  cache_pkg::block_t    victim_block,
  output logic                 mem_req_valid,
  input  logic                 mem_req_ready,
  output logic                 mem_req_write,
  output cache_pkg::word_t     mem_req_addr,
  output cache_pkg::block_t    mem_req_wblock,
  input  logic                 mem_rsp_valid,
  input  cache_pkg::block_t    mem_rsp_rblock,
  output cache_pkg::block_t    fill_block
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_req_valid <= 1'b0;
    end else if (mem_start) begin
      mem_req_valid <= 1'b1;
    end else if (mem_req_ready) begin
      mem_req_valid <= 1'b0;  // Accepted, or already idle
    end
  end

  // Block aligned address, victim's own tag on a write-back
  always_ff @(posedge clk) begin
    if (mem_start) begin
      mem_req_write  <= mem_write;
      mem_req_addr   <= {(mem_write ? victim_tag : req_tag), req_index,
                         {cache_pkg::offset_bits{1'b0}}};
      mem_req_wblock <= victim_block;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_rsp_valid) fill_block <= mem_rsp_rblock;  // Write ack loads junk, unused
  end

endmodule

`default_nettype wire

// ==== logic/cache_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_fsm (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req_fire,
  input  logic                      hit,
  input  logic                      need_write_back,
  input  logic                      mem_rsp_valid,
  input  logic                      rsp_done,
  output cache_pkg::cache_state_e   state,
  output logic                      idle,
  output logic                      mem_start,
  output logic                      mem_write,
  output logic                      wr_en,
  output logic                      rsp_load
);

  cache_pkg::cache_state_e state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      cache_pkg::st_idle:
        if (req_fire) state_nxt = cache_pkg::st_lookup;
      cache_pkg::st_lookup: begin
        if (hit)
          state_nxt = cache_pkg::st_update;
        else if (need_write_back)
          state_nxt = cache_pkg::st_write_back;  // Dirty victim goes out first
        else
          state_nxt = cache_pkg::st_fill;
      end
      cache_pkg::st_write_back:
        if (mem_rsp_valid) state_nxt = cache_pkg::st_fill;
      cache_pkg::st_fill:
        if (mem_rsp_valid) state_nxt = cache_pkg::st_update;
      cache_pkg::st_update:
        state_nxt = cache_pkg::st_respond;
      cache_pkg::st_respond:
        if (rsp_done) state_nxt = cache_pkg::st_idle;
      default:
        state_nxt = cache_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state <= cache_pkg::st_idle;
    else        state <= state_nxt;
  end

  assign idle = (state == cache_pkg::st_idle);

  // Memory request on entry to st_write_back or st_fill
  assign mem_start = ((state == cache_pkg::st_lookup) && !hit) ||
                     ((state == cache_pkg::st_write_back) && mem_rsp_valid);
  assign mem_write = (state == cache_pkg::st_lookup) && !hit && need_write_back;

  // Store write and response capture share the st_update edge
  assign wr_en    = (state == cache_pkg::st_update);
  assign rsp_load = (state == cache_pkg::st_update);

  // Memory phases end only on a memory response
  assert property (@(posedge clk) disable iff (!rst_n)
    (state inside {cache_pkg::st_write_back, cache_pkg::st_fill}) && !mem_rsp_valid
      |=> $stable(state))
    else $error("memory phase left without response");

endmodule

`default_nettype wire

// ==== logic/line_update.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_update (
  input  cache_pkg::cpu_op_e   req_op,
  input  cache_pkg::offset_t   req_offset,
  input  cache_pkg::word_t     req_wdata,
  input  logic                 hit,
  input  logic                 hit_dirty,   // Dirty bit of the hit way
  input  cache_pkg::block_t    hit_block,
  input  cache_pkg::block_t    fill_block,
  output cache_pkg::block_t    new_block,
  output logic                 new_dirty,
  output cache_pkg::word_t     rsp_word
);

  cache_pkg::block_t base_block;

  assign base_block = hit ? hit_block : fill_block;  // Fill data on a miss

  // Merge the CPU word into the block on a write
  always_comb begin
    new_block = base_block;
    if (req_op == cache_pkg::op_write)
      new_block[req_offset*cache_pkg::word_bits +: cache_pkg::word_bits] = req_wdata;
  end

  // Write sets dirty, read miss brings clean data, read hit keeps it
  assign new_dirty = (req_op == cache_pkg::op_write) || (hit && hit_dirty);

  assign rsp_word = base_block[req_offset*cache_pkg::word_bits +: cache_pkg::word_bits];

endmodule

`default_nettype wire

// ==== logic/hit_lru_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module hit_lru_unit (
  input  cache_pkg::tag_t                              req_tag,
  input  cache_pkg::way_vec_t                          line_valid,
  input  cache_pkg::way_vec_t                          line_dirty,
  input  cache_pkg::age_t   [cache_pkg::ways-1:0]      line_age,
  input  cache_pkg::tag_t   [cache_pkg::ways-1:0]      line_tag,
  input  cache_pkg::block_t [cache_pkg::ways-1:0]      line_block,
  output cache_pkg::way_vec_t                          hit_way,
  output logic                                         hit,
  output cache_pkg::way_vec_t                          victim_way,
  output logic                                         need_write_back,
  output cache_pkg::tag_t                              victim_tag,
  output cache_pkg::block_t                            victim_block,
  output cache_pkg::way_vec_t                          target_way,
  output cache_pkg::age_t   [cache_pkg::ways-1:0]      new_age
);

  logic [cache_pkg::age_bits:0] target_age;  // Extra bit, invalid target reads as 4

  always_comb begin
    for (int i = 0; i < cache_pkg::ways; i++) begin
      hit_way[i] = line_valid[i] && (line_tag[i] == req_tag);
    end
  end

  assign hit = |hit_way;

  // Invalid ways are used first, lowest number wins
  always_comb begin
    victim_way = '0;
    if (&line_valid) begin
      for (int i = 0; i < cache_pkg::ways; i++) victim_way[i] = (line_age[i] == '1);
    end else begin
      for (int i = cache_pkg::ways - 1; i >= 0; i--) begin
        if (!line_valid[i]) begin
          victim_way    = '0;
          victim_way[i] = 1'b1;
        end
      end
    end
  end

  always_comb begin
    victim_tag   = '0;
    victim_block = '0;
    for (int i = 0; i < cache_pkg::ways; i++) begin
      if (victim_way[i]) begin
        victim_tag   = line_tag[i];
        victim_block = line_block[i];
      end
    end
  end

  assign need_write_back = |(victim_way & line_valid & line_dirty);
  assign target_way      = hit ? hit_way : victim_way;

  // Target becomes youngest, younger valid ways age by one
  always_comb begin
    target_age = 3'd4;
    for (int i = 0; i < cache_pkg::ways; i++) begin
      if (target_way[i] && line_valid[i]) target_age = {1'b0, line_age[i]};
    end
    for (int i = 0; i < cache_pkg::ways; i++) begin
      if (target_way[i])
        new_age[i] = '0;
      else if (line_valid[i] && ({1'b0, line_age[i]} < target_age))
        new_age[i] = line_age[i] + 1'b1;
      else
        new_age[i] = line_age[i];
    end
  end

  // Store invariants seen through the candidate lines
  always_comb begin
    if (!$isunknown(line_valid)) begin
      assert final ($onehot0(hit_way)) else $error("more than one way hits");
      if (&line_valid) begin
        assert final ($onehot(victim_way)) else $error("full set lacks a single age-3 way");
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/way_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module way_store (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  cache_pkg::index_t                            rd_index,
  output cache_pkg::way_vec_t                          line_valid,
  output cache_pkg::way_vec_t                          line_dirty,
  output cache_pkg::age_t   [cache_pkg::ways-1:0]      line_age,
  output cache_pkg::tag_t   [cache_pkg::ways-1:0]      line_tag,
  output cache_pkg::block_t [cache_pkg::ways-1:0]      line_block,
  input  logic                                         wr_en,
  input  cache_pkg::way_vec_t                          wr_way,
  input  cache_pkg::tag_t                              wr_tag,
  input  cache_pkg::block_t                            wr_block,
  input  logic                                         wr_dirty,
  input  cache_pkg::age_t   [cache_pkg::ways-1:0]      new_age
);

  // Per-set state, control bits cleared on reset
  cache_pkg::way_vec_t                          valid_q [cache_pkg::sets];
  cache_pkg::way_vec_t                          dirty_q [cache_pkg::sets];
  cache_pkg::age_t   [cache_pkg::ways-1:0]      age_q   [cache_pkg::sets];
  // Payload arrays
  cache_pkg::tag_t   [cache_pkg::ways-1:0]      tag_q   [cache_pkg::sets];
  cache_pkg::block_t [cache_pkg::ways-1:0]      data_q  [cache_pkg::sets];

  // Zero-cycle read of the whole set
  assign line_valid = valid_q[rd_index];
  assign line_dirty = dirty_q[rd_index];
  assign line_age   = age_q[rd_index];
  assign line_tag   = tag_q[rd_index];
  assign line_block = data_q[rd_index];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < cache_pkg::sets; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
        age_q[s]   <= '0;
      end
    end else if (wr_en) begin
      age_q[rd_index] <= new_age;  // All four ages of the set move together
      for (int w = 0; w < cache_pkg::ways; w++) begin
        if (wr_way[w]) begin
          valid_q[rd_index][w] <= 1'b1;
          dirty_q[rd_index][w] <= wr_dirty;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int w = 0; w < cache_pkg::ways; w++) begin
        if (wr_way[w]) begin
          tag_q[rd_index][w]  <= wr_tag;
          data_q[rd_index][w] <= wr_block;
        end
      end
    end
  end

  // Exactly one way written per access
  assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> $onehot(wr_way))
    else $error("wr_way not one-hot on write");

endmodule

`default_nettype wire

// ==== logic/cpu_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cpu_req_valid,
  output logic                 cpu_req_ready,
  input  cache_pkg::cpu_op_e   cpu_req_op,
  input  cache_pkg::word_t     cpu_req_addr,
  input  cache_pkg::word_t     cpu_req_wdata,
  output logic                 cpu_rsp_valid,
  output cache_pkg::word_t     cpu_rsp_rdata,
  input  logic                 cpu_rsp_ready,
  input  logic                 idle,
  input  logic                 rsp_load,
  input  cache_pkg::word_t     rsp_word,
  output logic                 req_fire,
  output cache_pkg::cpu_op_e   req_op,
  output cache_pkg::tag_t      req_tag,
  output cache_pkg::index_t    req_index,
  output cache_pkg::offset_t   req_offset,
  output cache_pkg::word_t     req_wdata,
  output logic                 rsp_done
);

  assign cpu_req_ready = idle;  // One access in flight
  assign req_fire      = cpu_req_valid & cpu_req_ready;
  assign rsp_done      = cpu_rsp_valid & cpu_rsp_ready;

  // Request capture, address split as tag | index | offset
  always_ff @(posedge clk) begin
    if (req_fire) begin
      req_op     <= cpu_req_op;
      req_wdata  <= cpu_req_wdata;
      req_offset <= cpu_req_addr[cache_pkg::offset_bits-1:0];
      req_index  <= cpu_req_addr[cache_pkg::offset_bits +: cache_pkg::index_bits];
      req_tag    <= cpu_req_addr[cache_pkg::word_bits-1 -: cache_pkg::tag_bits];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cpu_rsp_valid <= 1'b0;
    end else if (rsp_load) begin
      cpu_rsp_valid <= 1'b1;
    end else if (rsp_done) begin
      cpu_rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_load) cpu_rsp_rdata <= rsp_word;  // Held until the CPU takes it
  end

  // Stalled response keeps its word
  assert property (@(posedge clk) disable iff (!rst_n)
    cpu_rsp_valid && !cpu_rsp_ready |=> cpu_rsp_valid && $stable(cpu_rsp_rdata))
    else $error("response changed while stalled");

endmodule

`default_nettype wire

// ==== logic/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

  // Geometry, kept small for simulation
  localparam int word_bits   = 32;
  localparam int offset_bits = 2;   // Word within a block
  localparam int index_bits  = 4;
  localparam int tag_bits    = word_bits - index_bits - offset_bits;
  localparam int ways        = 4;
  localparam int age_bits    = 2;   // Age 3 is the oldest
  localparam int block_bits  = word_bits << offset_bits;
  localparam int sets        = 1 << index_bits;

  typedef logic [word_bits-1:0]   word_t;   // Data word, also word address
  typedef logic [tag_bits-1:0]    tag_t;
  typedef logic [index_bits-1:0]  index_t;
  typedef logic [offset_bits-1:0] offset_t;
  typedef logic [block_bits-1:0]  block_t;  // Word 0 in the low bits
  typedef logic [age_bits-1:0]    age_t;
  typedef logic [ways-1:0]        way_vec_t;

  typedef enum logic {
    op_read,
    op_write
  } cpu_op_e;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_write_back,
    st_fill,
    st_update,
    st_respond
  } cache_state_e;

endpackage

`default_nettype wire
